// ==== Bender.yml ====
package:
  name: apf_io

sources:
  - include_dirs:
      - logic
    files:
      - logic/apf_io_pkg.sv
      - logic/bridge_decoder.sv
      - logic/core_config_regs.sv
      - logic/pad_remap.sv
      - logic/ram_word_port.sv
      - logic/apf_io.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/apf_io_clock_gen.sv
      - verification/apf_io_props.sv
      - verification/apf_io_tb.sv

// ==== apf_io.f ====
+incdir+logic
logic/apf_io_pkg.sv
logic/bridge_decoder.sv
logic/core_config_regs.sv
logic/pad_remap.sv
logic/ram_word_port.sv
logic/apf_io.sv
verification/apf_io_clock_gen.sv
verification/apf_io_props.sv
verification/apf_io_tb.sv

// ==== logic/apf_io.sv ====
`timescale 1ns/1ps
`include "apf_io_config.svh"

module apf_io import apf_io_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       req_valid,
	output logic                       req_ready,
	input  logic                       req_write,
	input  bridge_word_t               req_addr,
	input  bridge_word_t               req_wdata,
	output logic                       rsp_valid,
	input  logic                       rsp_ready,
	output bridge_word_t               rsp_rdata,
	input  logic                       all_complete,
	input  key_map_t                   keys_1,
	input  key_map_t                   keys_2,
	output logic                       cram0_rd,
	output logic                       cram0_wr,
	output cram_addr_t                 cram0_addr,
	output cram_word_t                 cram0_data,
	input  cram_word_t                 cram0_q,
	input  logic                       cram0_busy,
	output logic                       memcard_rd,
	output logic                       memcard_wr,
	output memcard_addr_t              memcard_addr,
	output memcard_word_t              memcard_data,
	input  memcard_word_t              memcard_q,
	input  logic                       memcard_busy,
	output joy_word_t                  joystick_0,
	output joy_word_t                  joystick_1,
	output logic [`APF_DIPSW_W-1:0]    dipsw,
	output logic [`APF_SYSTYPE_W-1:0]  system_type,
	output logic [`APF_MCARD_EN_W-1:0] memory_card_enable,
	output cram_addr_t                 cram_mask,
	output logic                       start_system
);

	logic         cram_start;
	logic         cram_done;
	bridge_word_t cram_rdata;
	logic         mcard_start;
	logic         mcard_done;
	bridge_word_t mcard_rdata;
	logic         port_write;
	bridge_word_t port_addr;
	bridge_word_t port_wdata;
	logic         cfg_wr;
	bridge_word_t cfg_offset;
	bridge_word_t cfg_wdata;
	bridge_word_t cfg_rdata;
	logic         cram_wr_seen;
	layout_t      layout_1;
	layout_t      layout_2;

	bridge_decoder bridge_decoder_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_write    (req_write),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.rsp_rdata    (rsp_rdata),
		.cram_start   (cram_start),
		.cram_done    (cram_done),
		.cram_rdata   (cram_rdata),
		.mcard_start  (mcard_start),
		.mcard_done   (mcard_done),
		.mcard_rdata  (mcard_rdata),
		.port_write   (port_write),
		.port_addr    (port_addr),
		.port_wdata   (port_wdata),
		.cfg_wr       (cfg_wr),
		.cfg_offset   (cfg_offset),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.cram_wr_seen (cram_wr_seen)
	);

	// character RAM, 32-bit words at address bits 25:2
	ram_word_port #(
		.word_t (cram_word_t),
		.addr_t (cram_addr_t)
	) cram0_port_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.start     (cram_start),
		.write     (port_write),
		.addr      (port_addr),
		.wdata     (port_wdata),
		.done      (cram_done),
		.rdata     (cram_rdata),
		.mem_rd    (cram0_rd),
		.mem_wr    (cram0_wr),
		.mem_addr  (cram0_addr),
		.mem_wdata (cram0_data),
		.mem_q     (cram0_q),
		.mem_busy  (cram0_busy)
	);

	// memory card, 16-bit words at address bits 12:1
	ram_word_port #(
		.word_t (memcard_word_t),
		.addr_t (memcard_addr_t)
	) memcard_port_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.start     (mcard_start),
		.write     (port_write),
		.addr      (port_addr),
		.wdata     (port_wdata),
		.done      (mcard_done),
		.rdata     (mcard_rdata),
		.mem_rd    (memcard_rd),
		.mem_wr    (memcard_wr),
		.mem_addr  (memcard_addr),
		.mem_wdata (memcard_data),
		.mem_q     (memcard_q),
		.mem_busy  (memcard_busy)
	);

	// snooped cram address is the latched request address
	core_config_regs core_config_regs_inst (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cfg_wr             (cfg_wr),
		.cfg_offset         (cfg_offset),
		.cfg_wdata          (cfg_wdata),
		.cfg_rdata          (cfg_rdata),
		.cram_wr_seen       (cram_wr_seen),
		.cram_wr_addr       (port_addr),
		.all_complete       (all_complete),
		.p1_keys            (keys_1),
		.layout_1           (layout_1),
		.layout_2           (layout_2),
		.dipsw              (dipsw),
		.system_type        (system_type),
		.memory_card_enable (memory_card_enable),
		.cram_mask          (cram_mask),
		.start_system       (start_system)
	);

	// layout selectors steer the remapper
	pad_remap pad_remap_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.keys_1     (keys_1),
		.keys_2     (keys_2),
		.layout_1   (layout_1),
		.layout_2   (layout_2),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1)
	);

endmodule

// ==== logic/apf_io_config.svh ====
`ifndef APF_IO_CONFIG_SVH
`define APF_IO_CONFIG_SVH

// top address nibble of a bridge access
`define APF_REGION_CRAM0    4'h1
`define APF_REGION_MEMCARD  4'h6
`define APF_REGION_CONFIG   4'hF

// config block byte offsets within region F
`define APF_CFG_MAP1        32'h0000_0000
`define APF_CFG_MAP2        32'h0000_0004
`define APF_CFG_DIPSW       32'h0000_0008
`define APF_CFG_SYSTYPE     32'h0000_000C
`define APF_CFG_MCARD       32'h0000_0010

// pad layouts, anything else is the default layout
`define APF_LAYOUT_NEOGEO     4'h1
`define APF_LAYOUT_NEOGEO_CD  4'h2

// holding L1 on pad 1 keeps the system in reset
`define APF_KEY_L1          8

// field widths
`define APF_WORD_W          32
`define APF_KEY_W           16
`define APF_JOY_W           10
`define APF_LAYOUT_W        4
`define APF_CRAM_ADDR_W     24
`define APF_MCARD_WORD_W    16
`define APF_MCARD_ADDR_W    12
`define APF_DIPSW_W         8
`define APF_SYSTYPE_W       2
`define APF_MCARD_EN_W      2

`endif

// ==== logic/apf_io_pkg.sv ====
`include "apf_io_config.svh"

package apf_io_pkg;

	// bridge address or data word
	typedef logic [`APF_WORD_W-1:0] bridge_word_t;

	// raw pad keys
	// 0 up, 1 down, 2 left, 3 right, 4 a, 5 b, 6 x, 7 y
	// 8 L1, 14 select, 15 start
	typedef logic [`APF_KEY_W-1:0] key_map_t;

	// remapped joystick word as the core sees it
	typedef logic [`APF_JOY_W-1:0] joy_word_t;

	// controller layout selector
	typedef logic [`APF_LAYOUT_W-1:0] layout_t;

	// character RAM, 32-bit words
	typedef logic [`APF_WORD_W-1:0] cram_word_t;
	typedef logic [`APF_CRAM_ADDR_W-1:0] cram_addr_t;

	// memory card, 16-bit words
	typedef logic [`APF_MCARD_WORD_W-1:0] memcard_word_t;
	typedef logic [`APF_MCARD_ADDR_W-1:0] memcard_addr_t;

endpackage

// ==== logic/bridge_decoder.sv ====
`timescale 1ns/1ps
`include "apf_io_config.svh"

module bridge_decoder import apf_io_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         req_valid,
	output logic         req_ready,
	input  logic         req_write,
	input  bridge_word_t req_addr,
	input  bridge_word_t req_wdata,
	output logic         rsp_valid,
	input  logic         rsp_ready,
	output bridge_word_t rsp_rdata,
	output logic         cram_start,
	input  logic         cram_done,
	input  bridge_word_t cram_rdata,
	output logic         mcard_start,
	input  logic         mcard_done,
	input  bridge_word_t mcard_rdata,
	output logic         port_write,
	output bridge_word_t port_addr,
	output bridge_word_t port_wdata,
	output logic         cfg_wr,
	output bridge_word_t cfg_offset,
	output bridge_word_t cfg_wdata,
	input  bridge_word_t cfg_rdata,
	output logic         cram_wr_seen
);

	typedef enum logic [1:0] {st_idle, st_wait, st_resp} state_t;

	state_t       state;
	logic         accept;
	logic [3:0]   region;
	logic         write_q;
	logic         is_mcard_q;
	bridge_word_t addr_q;
	bridge_word_t wdata_q;
	logic         port_done;
	bridge_word_t port_rdata;

	// one access at a time, ready only when idle
	assign req_ready = (state == st_idle);
	assign accept    = req_valid && req_ready;
	assign region    = req_addr[31:28];
	assign rsp_valid = (state == st_resp);

	// config access happens right in the accept cycle
	assign cfg_wr     = accept && req_write && (region == `APF_REGION_CONFIG);
	assign cfg_offset = {4'h0, req_addr[27:0]};
	assign cfg_wdata  = req_wdata;

	// port fields come from the latched request, steady until done
	assign port_write = write_q;
	assign port_addr  = addr_q;
	assign port_wdata = wdata_q;

	// only the started port can answer
	assign port_done  = is_mcard_q ? mcard_done : cram_done;
	assign port_rdata = is_mcard_q ? mcard_rdata : cram_rdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= st_idle;
			cram_start   <= 1'b0;
			mcard_start  <= 1'b0;
			cram_wr_seen <= 1'b0;
		end else begin
			// start and snoop strobes last one cycle
			cram_start   <= 1'b0;
			mcard_start  <= 1'b0;
			cram_wr_seen <= 1'b0;
			case (state)
				st_idle: begin
					if (accept) begin
						case (region)
							`APF_REGION_CRAM0: begin
								cram_start   <= 1'b1;
								cram_wr_seen <= req_write;
								state        <= st_wait;
							end
							`APF_REGION_MEMCARD: begin
								mcard_start <= 1'b1;
								state       <= st_wait;
							end
							// config and unmapped answer next cycle
							default: state <= st_resp;
						endcase
					end
				end
				st_wait: begin
					if (port_done) begin
						state <= st_resp;
					end
				end
				st_resp: begin
					if (rsp_ready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			write_q    <= req_write;
			addr_q     <= req_addr;
			wdata_q    <= req_wdata;
			is_mcard_q <= (region == `APF_REGION_MEMCARD);
			// config read data, zero for writes and unmapped reads
			if (!req_write && region == `APF_REGION_CONFIG) begin
				rsp_rdata <= cfg_rdata;
			end else begin
				rsp_rdata <= '0;
			end
		end else if (state == st_wait && port_done) begin
			rsp_rdata <= write_q ? '0 : port_rdata;
		end
	end

endmodule

// ==== logic/core_config_regs.sv ====
`timescale 1ns/1ps
`include "apf_io_config.svh"

module core_config_regs import apf_io_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       cfg_wr,
	input  bridge_word_t               cfg_offset,
	input  bridge_word_t               cfg_wdata,
	output bridge_word_t               cfg_rdata,
	input  logic                       cram_wr_seen,
	input  bridge_word_t               cram_wr_addr,
	input  logic                       all_complete,
	input  key_map_t                   p1_keys,
	output layout_t                    layout_1,
	output layout_t                    layout_2,
	output logic [`APF_DIPSW_W-1:0]    dipsw,
	output logic [`APF_SYSTYPE_W-1:0]  system_type,
	output logic [`APF_MCARD_EN_W-1:0] memory_card_enable,
	output cram_addr_t                 cram_mask,
	output logic                       start_system
);

	localparam int mask_w = $bits(cram_addr_t);

	cram_addr_t word_addr;
	cram_addr_t smear;

	// word address of the snooped write, byte address bits 25:2
	assign word_addr = cram_wr_addr[2 +: mask_w];

	// bit i set when any word address bit at or above i is set
	always_comb begin
		smear[mask_w-1] = word_addr[mask_w-1];
		for (int i = mask_w - 2; i >= 0; i--) begin
			smear[i] = smear[i+1] | word_addr[i];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			layout_1           <= '0;
			layout_2           <= '0;
			dipsw              <= '0;
			system_type        <= '0;
			memory_card_enable <= '0;
			cram_mask          <= '0;
			start_system       <= 1'b0;
		end else begin
			// register writes keep only the low bits
			if (cfg_wr) begin
				case (cfg_offset)
					`APF_CFG_MAP1:    layout_1 <= cfg_wdata[`APF_LAYOUT_W-1:0];
					`APF_CFG_MAP2:    layout_2 <= cfg_wdata[`APF_LAYOUT_W-1:0];
					`APF_CFG_DIPSW:   dipsw <= cfg_wdata[`APF_DIPSW_W-1:0];
					`APF_CFG_SYSTYPE: system_type <= cfg_wdata[`APF_SYSTYPE_W-1:0];
					`APF_CFG_MCARD:   memory_card_enable <= cfg_wdata[`APF_MCARD_EN_W-1:0];
					default: ;
				endcase
			end
			// rolling rom mask from the last cram write
			if (cram_wr_seen) begin
				cram_mask <= smear;
			end
			// run once loaded, unless L1 held on pad 1
			start_system <= all_complete && !p1_keys[`APF_KEY_L1];
		end
	end

	// read back, zero-extended, unknown offsets read zero
	always_comb begin
		cfg_rdata = '0;
		case (cfg_offset)
			`APF_CFG_MAP1:    cfg_rdata = bridge_word_t'(layout_1);
			`APF_CFG_MAP2:    cfg_rdata = bridge_word_t'(layout_2);
			`APF_CFG_DIPSW:   cfg_rdata = bridge_word_t'(dipsw);
			`APF_CFG_SYSTYPE: cfg_rdata = bridge_word_t'(system_type);
			`APF_CFG_MCARD:   cfg_rdata = bridge_word_t'(memory_card_enable);
			default:          cfg_rdata = '0;
		endcase
	end

endmodule

// ==== logic/pad_remap.sv ====
`timescale 1ns/1ps
`include "apf_io_config.svh"

module pad_remap import apf_io_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  key_map_t  keys_1,
	input  key_map_t  keys_2,
	input  layout_t   layout_1,
	input  layout_t   layout_2,
	output joy_word_t joystick_0,
	output joy_word_t joystick_1
);

	// one pad through one layout
	function automatic joy_word_t remap(input key_map_t k, input layout_t sel);
		logic [3:0] face;
		// face buttons listed bit 7 down to bit 4
		case (sel)
			`APF_LAYOUT_NEOGEO:    face = {k[4], k[6], k[5], k[7]};
			`APF_LAYOUT_NEOGEO_CD: face = {k[6], k[7], k[4], k[5]};
			default:               face = {k[7], k[6], k[5], k[4]};
		endcase
		// select, start, face, then up down left right from bit 3
		return {k[14], k[15], face, k[0], k[1], k[2], k[3]};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
		end else begin
			joystick_0 <= remap(keys_1, layout_1);
			joystick_1 <= remap(keys_2, layout_2);
		end
	end

endmodule

// ==== logic/ram_word_port.sv ====
`timescale 1ns/1ps

module ram_word_port import apf_io_pkg::*; #(
	parameter type word_t = cram_word_t,
	parameter type addr_t = cram_addr_t
) (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         start,
	input  logic         write,
	input  bridge_word_t addr,
	input  bridge_word_t wdata,
	output logic         done,
	output bridge_word_t rdata,
	output logic         mem_rd,
	output logic         mem_wr,
	output addr_t        mem_addr,
	output word_t        mem_wdata,
	input  word_t        mem_q,
	input  logic         mem_busy
);

	// byte address lsb of a word, 2 for 32-bit and 1 for 16-bit
	localparam int addr_lsb = $clog2($bits(word_t) / 8);

	logic pending;

	// strobe goes out with start, rd and wr exclusive by write
	assign mem_rd = start && !write;
	assign mem_wr = start && write;

	// word address slice and truncated data
	assign mem_addr  = addr_t'(addr[addr_lsb +: $bits(addr_t)]);
	assign mem_wdata = word_t'(wdata);

	// finished on the first cycle busy is seen low
	assign done = pending && !mem_busy;

	// q is valid in the done cycle, widen to the bridge word
	assign rdata = bridge_word_t'(mem_q);

	// busy only counts from the cycle after the strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (start) begin
			pending <= 1'b1;
		end else if (done) begin
			pending <= 1'b0;
		end
	end

endmodule

// ==== verification/apf_io_clock_gen.sv ====
`timescale 1ns/1ps

module apf_io_clock_gen #(
	parameter real period_ns = 20.0
) (
	output logic clk_sys
);

	// free running, starts low
	initial begin
		clk_sys = 1'b0;
		forever begin
			#(period_ns / 2.0) clk_sys = ~clk_sys;
		end
	end

endmodule

// ==== verification/apf_io_props.sv ====
`timescale 1ns/1ps

module apf_io_props import apf_io_pkg::*; (
	input logic         clk_sys,
	input logic         reset,
	input logic         req_ready,
	input logic         rsp_valid,
	input logic         rsp_ready,
	input bridge_word_t rsp_rdata,
	input logic         cram0_rd,
	input logic         cram0_wr,
	input logic         memcard_rd,
	input logic         memcard_wr
);

	// nonzero once any property below has fired
	int unsigned assert_failures = 0;

	// pending response holds still until taken
	rsp_hold: assert property (@(posedge clk_sys) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
	else begin
		assert_failures = assert_failures + 1;
		$error("response changed or dropped before the host took it");
	end

	// no new request while a response waits
	busy_while_resp: assert property (@(posedge clk_sys) disable iff (reset)
		rsp_valid |-> !req_ready)
	else begin
		assert_failures = assert_failures + 1;
		$error("req_ready high while rsp_valid is high");
	end

	// read and write strobes exclusive on both ports
	strobe_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cram0_rd && cram0_wr) && !(memcard_rd && memcard_wr))
	else begin
		assert_failures = assert_failures + 1;
		$error("memory read and write strobes high together");
	end

endmodule

bind apf_io apf_io_props apf_io_props_inst (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.req_ready  (req_ready),
	.rsp_valid  (rsp_valid),
	.rsp_ready  (rsp_ready),
	.rsp_rdata  (rsp_rdata),
	.cram0_rd   (cram0_rd),
	.cram0_wr   (cram0_wr),
	.memcard_rd (memcard_rd),
	.memcard_wr (memcard_wr)
);

// ==== verification/apf_io_tb.sv ====
`timescale 1ns/1ps
`include "apf_io_config.svh"

module apf_io_tb import apf_io_pkg::*; ();

	localparam int reset_cycles = 4;
	localparam int n_cfg_rounds = 4;
	localparam int n_unmapped   = 8;
	localparam int n_cram_ops   = 200;
	localparam int n_mcard_ops  = 60;
	localparam int n_pad_cycles = 30;
	// bus accesses plus pad cycles
	localparam int n_trans = n_cfg_rounds * 10 + n_unmapped * 4 + n_cram_ops
		+ n_mcard_ops + 3 * (2 + n_pad_cycles);
	localparam int timeout_cycles = reset_cycles + n_trans * 40;

	logic                       clk_sys;
	logic                       reset;
	logic                       req_valid;
	logic                       req_ready;
	logic                       req_write;
	bridge_word_t               req_addr;
	bridge_word_t               req_wdata;
	logic                       rsp_valid;
	logic                       rsp_ready;
	bridge_word_t               rsp_rdata;
	logic                       all_complete;
	key_map_t                   keys_1;
	key_map_t                   keys_2;
	logic                       cram0_rd;
	logic                       cram0_wr;
	cram_addr_t                 cram0_addr;
	cram_word_t                 cram0_data;
	cram_word_t                 cram0_q;
	logic                       cram0_busy;
	logic                       memcard_rd;
	logic                       memcard_wr;
	memcard_addr_t              memcard_addr;
	memcard_word_t              memcard_data;
	memcard_word_t              memcard_q;
	logic                       memcard_busy;
	joy_word_t                  joystick_0;
	joy_word_t                  joystick_1;
	logic [`APF_DIPSW_W-1:0]    dipsw;
	logic [`APF_SYSTYPE_W-1:0]  system_type;
	logic [`APF_MCARD_EN_W-1:0] memory_card_enable;
	cram_addr_t                 cram_mask;
	logic                       start_system;

	// memories as the DUT sees them
	cram_word_t    cram_mem [cram_addr_t];
	memcard_word_t mcard_mem [memcard_addr_t];
	cram_addr_t    cram_addr_q = '0;
	memcard_addr_t mcard_addr_q = '0;
	int            cram_left = 0;
	int            mcard_left = 0;

	// reference model, host view
	cram_word_t    cram_ref [cram_addr_t];
	memcard_word_t mcard_ref [memcard_addr_t];
	// map1, map2, dipsw, system type, card enable
	bridge_word_t  cfg_model [5];
	cram_addr_t    mask_model;

	apf_io_clock_gen clock_gen_inst (
		.clk_sys (clk_sys)
	);

	apf_io apf_io_inst (.*);

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input bridge_word_t got,
			input bridge_word_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_joy(input string name, input joy_word_t got, input joy_word_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mask(input string name, input cram_addr_t got, input cram_addr_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// unwritten locations, pattern from the whole address
	function automatic cram_word_t cram_fill(input cram_addr_t wa);
		return {wa[7:0], wa} ^ 32'h5a5a_5a5a;
	endfunction

	function automatic memcard_word_t mcard_fill(input memcard_addr_t ma);
		return {4'hc, ma} ^ 16'h0f0f;
	endfunction

	// mask bit i set when the word address is at least 2**i
	function automatic cram_addr_t smeared(input cram_addr_t wa);
		cram_addr_t m;
		for (int i = 0; i < $bits(cram_addr_t); i++) begin
			m[i] = ((wa >> i) != 0);
		end
		return m;
	endfunction

	// low bit first, 0 right 1 left 2 down 3 up, 8 start 9 select
	function automatic joy_word_t expected_joy(input key_map_t k, input layout_t sel);
		joy_word_t j;
		j[0] = k[3];
		j[1] = k[2];
		j[2] = k[1];
		j[3] = k[0];
		j[8] = k[15];
		j[9] = k[14];
		if (sel == `APF_LAYOUT_NEOGEO) begin
			// y b x a
			j[4] = k[7];
			j[5] = k[5];
			j[6] = k[6];
			j[7] = k[4];
		end else if (sel == `APF_LAYOUT_NEOGEO_CD) begin
			// b a y x
			j[4] = k[5];
			j[5] = k[4];
			j[6] = k[7];
			j[7] = k[6];
		end else begin
			j[7:4] = k[7:4];
		end
		return j;
	endfunction

	function automatic bridge_word_t cfg_addr(input bridge_word_t off);
		return {`APF_REGION_CONFIG, off[27:0]};
	endfunction

	// character RAM, 0..N busy cycles after each strobe
	always @(posedge clk_sys) begin
		#1;
		cram0_busy = (cram_left > 0);
		if (cram_left > 0) begin
			cram0_q = 'x;
			cram_left = cram_left - 1;
		end else begin
			cram0_q = cram_mem.exists(cram_addr_q) ? cram_mem[cram_addr_q]
				: cram_fill(cram_addr_q);
		end
		if (cram0_rd || cram0_wr) begin
			if (cram0_wr) begin
				cram_mem[cram0_addr] = cram0_data;
			end
			cram_addr_q = cram0_addr;
			cram_left = $urandom_range(3, 0);
		end
	end

	// memory card, same handshake
	always @(posedge clk_sys) begin
		#1;
		memcard_busy = (mcard_left > 0);
		if (mcard_left > 0) begin
			memcard_q = 'x;
			mcard_left = mcard_left - 1;
		end else begin
			memcard_q = mcard_mem.exists(mcard_addr_q) ? mcard_mem[mcard_addr_q]
				: mcard_fill(mcard_addr_q);
		end
		if (memcard_rd || memcard_wr) begin
			if (memcard_wr) begin
				mcard_mem[memcard_addr] = memcard_data;
			end
			mcard_addr_q = memcard_addr;
			mcard_left = $urandom_range(3, 0);
		end
	end

	// one request and its response, entered and left 1 ns after an edge
	task automatic bus_access(input logic write, input bridge_word_t addr,
			input bridge_word_t wdata, input logic quick, output bridge_word_t rdata);
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		req_wdata = wdata;
		while (!req_ready) begin
			@(posedge clk_sys);
			#1;
		end
		@(posedge clk_sys);
		#1;
		// junk fields while idle
		req_valid = 1'b0;
		req_write = 1'($urandom_range(1, 0));
		req_addr  = $urandom();
		req_wdata = $urandom();
		// config and unmapped answer right after accept
		if (quick) begin
			check_bit("rsp_valid", rsp_valid, 1'b1);
		end
		rsp_ready = ($urandom_range(2, 0) != 0);
		while (!(rsp_valid && rsp_ready)) begin
			@(posedge clk_sys);
			#1;
			rsp_ready = ($urandom_range(2, 0) != 0);
		end
		rdata = rsp_rdata;
		@(posedge clk_sys);
		#1;
		rsp_ready = 1'b0;
	endtask

	task automatic check_cfg_outputs();
		check_word("dipsw", bridge_word_t'(dipsw), cfg_model[2]);
		check_word("system_type", bridge_word_t'(system_type), cfg_model[3]);
		check_word("memory_card_enable", bridge_word_t'(memory_card_enable), cfg_model[4]);
	endtask

	task automatic config_test();
		bridge_word_t offs [5];
		int           widths [5];
		bridge_word_t value;
		bridge_word_t got;
		offs   = '{`APF_CFG_MAP1, `APF_CFG_MAP2, `APF_CFG_DIPSW, `APF_CFG_SYSTYPE,
			`APF_CFG_MCARD};
		widths = '{`APF_LAYOUT_W, `APF_LAYOUT_W, `APF_DIPSW_W, `APF_SYSTYPE_W,
			`APF_MCARD_EN_W};
		for (int r = 0; r < n_cfg_rounds; r++) begin
			for (int i = 0; i < 5; i++) begin
				value = $urandom();
				cfg_model[i] = value & ((32'h1 << widths[i]) - 32'h1);
				bus_access(1'b1, cfg_addr(offs[i]), value, 1'b1, got);
				check_word("rsp_rdata", got, '0);
				bus_access(1'b0, cfg_addr(offs[i]), $urandom(), 1'b1, got);
				check_word("rsp_rdata", got, cfg_model[i]);
			end
			check_cfg_outputs();
		end
	endtask

	// unmapped regions and unknown config offsets
	task automatic unmapped_test();
		logic [3:0]   region;
		bridge_word_t off;
		bridge_word_t got;
		for (int n = 0; n < n_unmapped; n++) begin
			do begin
				region = 4'($urandom_range(15, 0));
			end while (region == `APF_REGION_CRAM0 || region == `APF_REGION_MEMCARD
				|| region == `APF_REGION_CONFIG);
			bus_access(1'b1, {region, 28'($urandom())}, $urandom(), 1'b1, got);
			check_word("rsp_rdata", got, '0);
			bus_access(1'b0, {region, 28'($urandom())}, $urandom(), 1'b1, got);
			check_word("rsp_rdata", got, '0);
			off = 32'h14 + 4 * $urandom_range(1000, 0);
			bus_access(1'b1, cfg_addr(off), $urandom(), 1'b1, got);
			check_word("rsp_rdata", got, '0);
			bus_access(1'b0, cfg_addr(off), $urandom(), 1'b1, got);
			check_word("rsp_rdata", got, '0);
		end
		check_cfg_outputs();
	endtask

	task automatic cram_test();
		cram_addr_t   pool [16];
		cram_addr_t   wa;
		bridge_word_t value;
		bridge_word_t exp;
		bridge_word_t got;
		// spread of highest set bits, zero included
		pool[0] = '0;
		for (int i = 1; i < 16; i++) begin
			pool[i] = cram_addr_t'($urandom() >> $urandom_range(31, 8));
		end
		for (int n = 0; n < n_cram_ops; n++) begin
			wa = pool[$urandom_range(15, 0)];
			if ($urandom_range(1, 0) == 1) begin
				value = $urandom();
				cram_ref[wa] = value;
				mask_model = smeared(wa);
				bus_access(1'b1, {`APF_REGION_CRAM0, 2'b00, wa, 2'b00}, value, 1'b0, got);
				check_word("rsp_rdata", got, '0);
			end else begin
				exp = cram_ref.exists(wa) ? cram_ref[wa] : cram_fill(wa);
				bus_access(1'b0, {`APF_REGION_CRAM0, 2'b00, wa, 2'b00}, $urandom(), 1'b0, got);
				check_word("rsp_rdata", got, exp);
			end
			check_mask("cram_mask", cram_mask, mask_model);
		end
	endtask

	task automatic memcard_test();
		memcard_addr_t pool [8];
		memcard_addr_t ma;
		bridge_word_t  value;
		bridge_word_t  exp;
		bridge_word_t  got;
		for (int i = 0; i < 8; i++) begin
			pool[i] = memcard_addr_t'($urandom());
		end
		for (int n = 0; n < n_mcard_ops; n++) begin
			ma = pool[$urandom_range(7, 0)];
			if ($urandom_range(1, 0) == 1) begin
				value = $urandom();
				// only the low half reaches the card
				mcard_ref[ma] = value[15:0];
				bus_access(1'b1, {`APF_REGION_MEMCARD, 15'h0, ma, 1'b0}, value, 1'b0, got);
				check_word("rsp_rdata", got, '0);
			end else begin
				exp = {16'h0, mcard_ref.exists(ma) ? mcard_ref[ma] : mcard_fill(ma)};
				bus_access(1'b0, {`APF_REGION_MEMCARD, 15'h0, ma, 1'b0}, $urandom(), 1'b0, got);
				check_word("rsp_rdata", got, exp);
			end
		end
	endtask

	// remap and start_system, both one cycle behind the keys
	task automatic pad_test();
		layout_t      layouts [3];
		layout_t      l1;
		layout_t      l2;
		key_map_t     k1;
		key_map_t     k2;
		logic         ac;
		joy_word_t    held_0;
		joy_word_t    held_1;
		logic         held_ss;
		bridge_word_t got;
		layouts[0] = `APF_LAYOUT_NEOGEO;
		layouts[1] = `APF_LAYOUT_NEOGEO_CD;
		do begin
			layouts[2] = layout_t'($urandom_range(15, 0));
		end while (layouts[2] == `APF_LAYOUT_NEOGEO || layouts[2] == `APF_LAYOUT_NEOGEO_CD);
		for (int li = 0; li < 3; li++) begin
			l1 = layouts[li];
			l2 = layouts[(li + 1) % 3];
			bus_access(1'b1, cfg_addr(`APF_CFG_MAP1), {28'($urandom_range(255, 0)), l1},
				1'b1, got);
			bus_access(1'b1, cfg_addr(`APF_CFG_MAP2), {28'($urandom_range(255, 0)), l2},
				1'b1, got);
			for (int n = 0; n < n_pad_cycles; n++) begin
				k1 = $urandom();
				k2 = $urandom();
				ac = ($urandom_range(3, 0) != 0);
				// outputs keep the keys of the cycle before until the edge
				held_0  = expected_joy(keys_1, l1);
				held_1  = expected_joy(keys_2, l2);
				held_ss = all_complete && !keys_1[`APF_KEY_L1];
				keys_1 = k1;
				keys_2 = k2;
				all_complete = ac;
				#5;
				check_joy("joystick_0", joystick_0, held_0);
				check_joy("joystick_1", joystick_1, held_1);
				check_bit("start_system", start_system, held_ss);
				@(posedge clk_sys);
				#1;
				check_joy("joystick_0", joystick_0, expected_joy(k1, l1));
				check_joy("joystick_1", joystick_1, expected_joy(k2, l2));
				check_bit("start_system", start_system, ac && !k1[`APF_KEY_L1]);
			end
		end
	endtask

	initial begin
		repeat (timeout_cycles) @(posedge clk_sys);
		$display("timeout: tests did not finish within %0d cycles", timeout_cycles);
		abort_run();
	end

	initial begin
		wait (apf_io_inst.apf_io_props_inst.assert_failures != 0);
		$display("assertion in apf_io_props failed at %0t ns", $time);
		abort_run();
	end

	initial begin
		void'($urandom(42959));
		reset        = 1'b1;
		req_valid    = 1'b0;
		req_write    = 1'b0;
		req_addr     = '0;
		req_wdata    = '0;
		rsp_ready    = 1'b0;
		all_complete = 1'b0;
		keys_1       = '0;
		keys_2       = '0;
		cram0_q      = '0;
		cram0_busy   = 1'b0;
		memcard_q    = '0;
		memcard_busy = 1'b0;
		cfg_model    = '{default: '0};
		mask_model   = '0;
		repeat (reset_cycles) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		// values left by reset
		check_bit("req_ready", req_ready, 1'b1);
		check_bit("rsp_valid", rsp_valid, 1'b0);
		check_bit("start_system", start_system, 1'b0);
		check_mask("cram_mask", cram_mask, '0);
		check_joy("joystick_0", joystick_0, '0);
		check_joy("joystick_1", joystick_1, '0);
		check_cfg_outputs();
		config_test();
		unmapped_test();
		cram_test();
		memcard_test();
		pad_test();
		if (apf_io_inst.apf_io_props_inst.assert_failures != 0) begin
			$display("assertion in apf_io_props failed during the run");
			abort_run();
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule
